//--- verilog.f
u2_ctrl_pkg.sv
pps_timer.sv
control_regs.sv
irq_controller.sv
output_lines.sv
readback_mux.sv
u2_control_core.sv
tb_u2_control_core.sv

//--- tb_u2_control_core.sv
// Self-checking testbench for the board control core.
// Drives settings writes, reads, interrupt sources and PPS, and checks against a model.
`timescale 1ns/100ps
`default_nettype none

module tb_u2_control_core;

   localparam int          PAGE_BITS  = 10;
   localparam int          TIME_W     = 32;
   localparam int          CLK_PERIOD = 8;
   localparam int          ACK_LIMIT  = 1;
   localparam logic [31:0] SEED       = 32'h384a_8896;
   // Upper bound of the cycles used by the test sequence
   localparam int          TEST_CYCLES = 460;

   logic                           dsp_clk;
   logic                           rst_n_i;
   u2_ctrl_pkg::settings_t         set_i;
   logic                           rd_stb_i;
   logic [3:0]                     rd_addr_i;
   logic [31:0]                    rd_data_o;
   logic                           rd_ack_o;
   logic                           pps_i;
   logic                           phy_int_n_i;
   logic                           link_up_i;
   logic                           clk_status_i;
   logic                           sim_mode_i;
   logic [3:0]                     clock_divider_i;
   u2_ctrl_pkg::clock_ctrl_t       clock_ctrl_o;
   u2_ctrl_pkg::serdes_ctrl_t      serdes_ctrl_o;
   u2_ctrl_pkg::adc_ctrl_t         adc_ctrl_o;
   logic [7:0]                     leds_o;
   logic                           phy_reset_n_o;
   logic [19-PAGE_BITS:0]          ram_page_o;
   logic                           irq_o;

   // Model of the register bank, interrupt state and time
   logic [4:0]  mdl_clock;
   logic [3:0]  mdl_serdes;
   logic [3:0]  mdl_adc;
   logic [7:0]  mdl_led_sw;
   logic [7:0]  mdl_led_src;
   logic        mdl_phy;
   logic [19:0] mdl_page;
   logic [7:0]  mdl_mask;
   logic [7:0]  mdl_pend;
   logic [7:0]  mdl_src_prev;
   logic        mdl_bus_err;
   logic [31:0] mdl_pps_time;
   logic [31:0] edge_cnt;

   logic [31:0] exp_data_q [$];
   logic [3:0]  exp_addr_q [$];
   logic [31:0] cmp_data;
   logic [3:0]  cmp_addr;
   int          err_cnt;
   int          seed_val;

   // Write order matches readback words 0 to 7
   logic [7:0] wr_addrs [0:7] = '{u2_ctrl_pkg::SR_CLOCK, u2_ctrl_pkg::SR_SERDES,
                                  u2_ctrl_pkg::SR_ADC, u2_ctrl_pkg::SR_LED,
                                  u2_ctrl_pkg::SR_PHY, u2_ctrl_pkg::SR_PAGE,
                                  u2_ctrl_pkg::SR_LED_SRC, u2_ctrl_pkg::SR_IRQ_MASK};

   u2_control_core #(.PAGE_BITS(PAGE_BITS), .TIME_W(TIME_W)) uut (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .set_i(set_i),
      .rd_stb_i(rd_stb_i), .rd_addr_i(rd_addr_i),
      .rd_data_o(rd_data_o), .rd_ack_o(rd_ack_o),
      .pps_i(pps_i), .phy_int_n_i(phy_int_n_i), .link_up_i(link_up_i),
      .clk_status_i(clk_status_i), .sim_mode_i(sim_mode_i),
      .clock_divider_i(clock_divider_i),
      .clock_ctrl_o(clock_ctrl_o), .serdes_ctrl_o(serdes_ctrl_o),
      .adc_ctrl_o(adc_ctrl_o), .leds_o(leds_o),
      .phy_reset_n_o(phy_reset_n_o), .ram_page_o(ram_page_o), .irq_o(irq_o)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #(CLK_PERIOD / 2) dsp_clk = ~dsp_clk;
   end

   // Edges seen out of reset, the reference for PPS time
   always @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         edge_cnt <= '0;
      end else begin
         edge_cnt <= edge_cnt + 1;
      end
   end

   initial begin
      #(TEST_CYCLES * CLK_PERIOD * 2);
      $display("ERROR: watchdog expired, the test sequence did not finish in time");
      fail_run();
   end

   ////////////////////////////////////////////////////////////
   // Checking helpers

   task automatic fail_run();
      $display("TESTS FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         err_cnt++;
         $display("ERROR at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
         fail_run();
      end
   endtask

   function automatic logic [31:0] expected_word(input logic [3:0] addr);
      case (addr)
         u2_ctrl_pkg::RB_CLOCK:    return 32'(mdl_clock);
         u2_ctrl_pkg::RB_SERDES:   return 32'(mdl_serdes);
         u2_ctrl_pkg::RB_ADC:      return 32'(mdl_adc);
         u2_ctrl_pkg::RB_LED:      return 32'(mdl_led_sw);
         u2_ctrl_pkg::RB_PHY:      return 32'(mdl_phy);
         u2_ctrl_pkg::RB_PAGE:     return 32'(mdl_page);
         u2_ctrl_pkg::RB_LED_SRC:  return 32'(mdl_led_src);
         u2_ctrl_pkg::RB_IRQ_MASK: return 32'(mdl_mask);
         u2_ctrl_pkg::RB_IRQ_PEND: return 32'(mdl_pend);
         u2_ctrl_pkg::RB_PPS_TIME: return mdl_pps_time;
         u2_ctrl_pkg::RB_STATUS:   return {sim_mode_i, mdl_bus_err, 26'b0, clock_divider_i};
         default:                  return 32'b0;
      endcase
   endfunction

   // Read data compare on each ack
   always @(negedge dsp_clk) begin
      if (rst_n_i && rd_ack_o === 1'b1) begin
         if (exp_data_q.size() == 0) begin
            $display("ERROR at %0t ns: read ack seen with no read outstanding", $time);
            fail_run();
         end else begin
            cmp_data = exp_data_q.pop_front();
            cmp_addr = exp_addr_q.pop_front();
            check_value($sformatf("rd_data_o (word %0d)", cmp_addr), rd_data_o, cmp_data);
         end
      end
   end

   task automatic check_pins();
      logic [7:0] led_hw;
      logic [7:0] led_exp;
      led_hw = {6'b0, clk_status_i, link_up_i};
      // Each LED picks its hardware or software value on its own
      for (int k = 0; k < 8; k++) begin
         led_exp[k] = mdl_led_src[k] ? led_hw[k] : mdl_led_sw[k];
      end
      check_value("clock_ctrl_o", clock_ctrl_o, mdl_clock);
      check_value("serdes_ctrl_o", serdes_ctrl_o, mdl_serdes);
      check_value("adc_ctrl_o", adc_ctrl_o, mdl_adc);
      check_value("leds_o", leds_o, led_exp);
      check_value("phy_reset_n_o", phy_reset_n_o, {31'b0, ~mdl_phy});
      check_value("ram_page_o", ram_page_o, mdl_page[19:PAGE_BITS]);
      check_value("irq_o", irq_o, |(mdl_pend & mdl_mask));
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus helpers

   task automatic step_clk();
      @(posedge dsp_clk);
      #1;
   endtask

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      logic was_err;
      was_err     = mdl_bus_err;
      set_i.stb   = 1'b1;
      set_i.addr  = addr;
      set_i.data  = data;
      step_clk();
      set_i.stb   = 1'b0;
      case (addr)
         u2_ctrl_pkg::SR_CLOCK:     mdl_clock   = data[4:0];
         u2_ctrl_pkg::SR_SERDES:    mdl_serdes  = data[3:0];
         u2_ctrl_pkg::SR_ADC:       mdl_adc     = data[3:0];
         u2_ctrl_pkg::SR_LED:       mdl_led_sw  = data[7:0];
         u2_ctrl_pkg::SR_PHY:       mdl_phy     = data[0];
         // Page offset bits read back as zero
         u2_ctrl_pkg::SR_PAGE:      mdl_page    = {data[19:PAGE_BITS], {PAGE_BITS{1'b0}}};
         u2_ctrl_pkg::SR_LED_SRC:   mdl_led_src = data[7:0];
         u2_ctrl_pkg::SR_IRQ_MASK:  mdl_mask    = data[7:0];
         u2_ctrl_pkg::SR_IRQ_CLEAR: mdl_bus_err = mdl_bus_err;
         default:                   mdl_bus_err = 1'b1;
      endcase
      step_clk();
      // Clear and bus error edge reach the pending bits one edge later
      if (addr == u2_ctrl_pkg::SR_IRQ_CLEAR) begin
         mdl_pend = mdl_pend & ~data[7:0];
      end
      if (mdl_bus_err && !was_err) begin
         mdl_pend[u2_ctrl_pkg::IRQ_BUS_ERR] = 1'b1;
      end
   endtask

   task automatic read_check(input logic [3:0] addr);
      int waited;
      rd_stb_i  = 1'b1;
      rd_addr_i = addr;
      exp_addr_q.push_back(addr);
      exp_data_q.push_back(expected_word(addr));
      step_clk();
      rd_stb_i = 1'b0;
      waited   = 0;
      while (exp_data_q.size() != 0) begin
         if (waited == ACK_LIMIT) begin
            $display("ERROR at %0t ns: no read ack for word %0d", $time, addr);
            fail_run();
         end
         @(negedge dsp_clk);
         #1;
         waited++;
      end
      step_clk();
   endtask

   task automatic drive_sources(input logic phy_n, input logic link, input logic clk_st);
      logic [7:0] src_now;
      phy_int_n_i  = phy_n;
      link_up_i    = link;
      clk_status_i = clk_st;
      src_now      = '0;
      src_now[u2_ctrl_pkg::IRQ_PHY]        = ~phy_n;
      src_now[u2_ctrl_pkg::IRQ_LINK]       = link;
      src_now[u2_ctrl_pkg::IRQ_CLK_STATUS] = clk_st;
      step_clk();
      mdl_pend     = mdl_pend | (src_now & ~mdl_src_prev);
      mdl_src_prev = src_now;
   endtask

   task automatic pulse_pps();
      logic [31:0] exp_time;
      pps_i    = 1'b1;
      exp_time = edge_cnt + 2;
      // Synchronizer, edge detect, then capture
      repeat (3) step_clk();
      mdl_pps_time = exp_time;
      mdl_pend[u2_ctrl_pkg::IRQ_PPS] = 1'b1;
      pps_i = 1'b0;
      repeat (4) step_clk();
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence

   initial begin
      int          idx;
      logic [7:0]  bad_addr;
      seed_val        = $urandom(SEED);
      err_cnt         = 0;
      rst_n_i         = 1'b0;
      set_i           = '0;
      rd_stb_i        = 1'b0;
      rd_addr_i       = '0;
      pps_i           = 1'b0;
      phy_int_n_i     = 1'b1;
      link_up_i       = 1'b0;
      clk_status_i    = 1'b0;
      sim_mode_i      = $urandom_range(0, 1);
      clock_divider_i = $urandom_range(0, 15);
      mdl_clock       = '0;
      mdl_serdes      = '0;
      mdl_adc         = '0;
      mdl_led_sw      = '0;
      mdl_led_src     = '0;
      mdl_phy         = 1'b0;
      mdl_page        = '0;
      mdl_mask        = '0;
      mdl_pend        = '0;
      mdl_src_prev    = '0;
      mdl_bus_err     = 1'b0;
      mdl_pps_time    = '0;
      repeat (5) @(posedge dsp_clk);
      #1;
      rst_n_i = 1'b1;
      step_clk();

      // Reset state, all sixteen words
      check_pins();
      for (int a = 0; a < 16; a++) begin
         read_check(4'(a));
      end

      // Register writes and pin mapping
      for (int i = 0; i < 24; i++) begin
         idx = $urandom_range(0, 7);
         write_setting(wr_addrs[idx], $urandom);
         check_pins();
         read_check(4'(idx));
      end

      // LED source select
      for (int i = 0; i < 16; i++) begin
         write_setting(u2_ctrl_pkg::SR_LED, $urandom);
         write_setting(u2_ctrl_pkg::SR_LED_SRC, $urandom);
         drive_sources(1'b1, $urandom_range(0, 1), $urandom_range(0, 1));
         check_pins();
      end

      // Interrupt edges, mask and clear
      write_setting(u2_ctrl_pkg::SR_IRQ_MASK, 32'h0);
      drive_sources(1'b1, 1'b0, 1'b0);
      write_setting(u2_ctrl_pkg::SR_IRQ_CLEAR, 32'hff);
      read_check(u2_ctrl_pkg::RB_IRQ_PEND);
      drive_sources(1'b0, 1'b0, 1'b0);
      drive_sources(1'b0, 1'b1, 1'b0);
      drive_sources(1'b0, 1'b1, 1'b1);
      check_pins();
      read_check(u2_ctrl_pkg::RB_IRQ_PEND);
      for (int b = 2; b <= 4; b++) begin
         write_setting(u2_ctrl_pkg::SR_IRQ_MASK, 32'h1 << b);
         check_pins();
         write_setting(u2_ctrl_pkg::SR_IRQ_CLEAR, 32'h1 << b);
         check_pins();
         read_check(u2_ctrl_pkg::RB_IRQ_PEND);
      end
      for (int i = 0; i < 12; i++) begin
         drive_sources($urandom_range(0, 1), $urandom_range(0, 1), $urandom_range(0, 1));
         write_setting(u2_ctrl_pkg::SR_IRQ_MASK, $urandom);
         check_pins();
         write_setting(u2_ctrl_pkg::SR_IRQ_CLEAR, $urandom);
         check_pins();
         read_check(u2_ctrl_pkg::RB_IRQ_PEND);
      end

      // Unmapped address sets the bus error
      bad_addr = 8'd11 + 8'($urandom_range(0, 244));
      write_setting(bad_addr, $urandom);
      check_pins();
      read_check(u2_ctrl_pkg::RB_STATUS);
      read_check(u2_ctrl_pkg::RB_IRQ_PEND);

      // PPS capture
      for (int i = 0; i < 3; i++) begin
         repeat ($urandom_range(1, 12)) step_clk();
         pulse_pps();
         read_check(u2_ctrl_pkg::RB_PPS_TIME);
         read_check(u2_ctrl_pkg::RB_IRQ_PEND);
         check_pins();
         write_setting(u2_ctrl_pkg::SR_IRQ_CLEAR, 32'h2);
         read_check(u2_ctrl_pkg::RB_IRQ_PEND);
      end

      if (err_cnt == 0) begin
         $display("TESTS PASSED");
         $finish;
      end else begin
         fail_run();
      end
   end

endmodule

`default_nettype wire

//--- u2_control_core.sv
// Top level of the board control and status core.
// Connects settings registers, pin drivers, interrupts, PPS timer and readback.
`timescale 1ns/100ps
`default_nettype none

module u2_control_core #(
   parameter int PAGE_BITS = 10,
   parameter int TIME_W    = 32
) (
   input  logic                        dsp_clk,
   input  logic                        rst_n_i,
   input  u2_ctrl_pkg::settings_t      set_i,
   input  logic                        rd_stb_i,
   input  logic [3:0]                  rd_addr_i,
   output logic [31:0]                 rd_data_o,
   output logic                        rd_ack_o,
   input  logic                        pps_i,
   input  logic                        phy_int_n_i,
   input  logic                        link_up_i,
   input  logic                        clk_status_i,
   input  logic                        sim_mode_i,
   input  logic [3:0]                  clock_divider_i,
   output u2_ctrl_pkg::clock_ctrl_t    clock_ctrl_o,
   output u2_ctrl_pkg::serdes_ctrl_t   serdes_ctrl_o,
   output u2_ctrl_pkg::adc_ctrl_t      adc_ctrl_o,
   output logic [7:0]                  leds_o,
   output logic                        phy_reset_n_o,
   output logic [19-PAGE_BITS:0]       ram_page_o,
   output logic                        irq_o
);

   u2_ctrl_pkg::ctrl_regs_t       regs;
   logic [u2_ctrl_pkg::IRQ_W-1:0] irq_clear;
   logic [u2_ctrl_pkg::IRQ_W-1:0] irq_src;
   logic [u2_ctrl_pkg::IRQ_W-1:0] irq_pending;
   logic                          bus_err;
   logic                          pps_pulse;
   logic [TIME_W-1:0]             pps_time;

   ////////////////////////////////////////////////////////////
   // Input side

   pps_timer #(.TIME_W(TIME_W)) u_pps_timer (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .pps_i(pps_i),
      .pps_pulse_o(pps_pulse), .pps_time_o(pps_time)
   );

   ////////////////////////////////////////////////////////////
   // Registers and interrupts

   control_regs #(.PAGE_BITS(PAGE_BITS)) u_control_regs (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .set_i(set_i),
      .regs_o(regs), .irq_clear_o(irq_clear), .bus_err_o(bus_err)
   );

   // PHY interrupt pin is open drain, active low
   always_comb begin
      irq_src = '0;
      irq_src[u2_ctrl_pkg::IRQ_BUS_ERR]    = bus_err;
      irq_src[u2_ctrl_pkg::IRQ_PPS]        = pps_pulse;
      irq_src[u2_ctrl_pkg::IRQ_PHY]        = ~phy_int_n_i;
      irq_src[u2_ctrl_pkg::IRQ_LINK]       = link_up_i;
      irq_src[u2_ctrl_pkg::IRQ_CLK_STATUS] = clk_status_i;
   end

   irq_controller u_irq_controller (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .src_i(irq_src),
      .mask_i(regs.irq_mask), .clear_i(irq_clear),
      .pending_o(irq_pending), .irq_o(irq_o)
   );

   ////////////////////////////////////////////////////////////
   // Output side

   output_lines #(.PAGE_BITS(PAGE_BITS)) u_output_lines (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .regs_i(regs),
      .led_hw_i({clk_status_i, link_up_i}),
      .clock_ctrl_o(clock_ctrl_o), .serdes_ctrl_o(serdes_ctrl_o),
      .adc_ctrl_o(adc_ctrl_o), .leds_o(leds_o),
      .phy_reset_n_o(phy_reset_n_o), .ram_page_o(ram_page_o)
   );

   readback_mux #(.TIME_W(TIME_W)) u_readback_mux (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i),
      .rd_stb_i(rd_stb_i), .rd_addr_i(rd_addr_i),
      .regs_i(regs), .pending_i(irq_pending), .pps_time_i(pps_time),
      .bus_err_i(bus_err), .sim_mode_i(sim_mode_i),
      .clock_divider_i(clock_divider_i),
      .rd_data_o(rd_data_o), .rd_ack_o(rd_ack_o)
   );

endmodule

`default_nettype wire

//--- readback_mux.sv
// Host readback of the register bank, pending interrupts, PPS time and status.
// A read strobe is answered one cycle later with data and a single cycle ack.
`timescale 1ns/100ps
`default_nettype none

module readback_mux #(
   parameter int TIME_W = 32
) (
   input  logic                          dsp_clk,
   input  logic                          rst_n_i,
   input  logic                          rd_stb_i,
   input  logic [3:0]                    rd_addr_i,
   input  u2_ctrl_pkg::ctrl_regs_t       regs_i,
   input  logic [u2_ctrl_pkg::IRQ_W-1:0] pending_i,
   input  logic [TIME_W-1:0]             pps_time_i,
   input  logic                          bus_err_i,
   input  logic                          sim_mode_i,
   input  logic [3:0]                    clock_divider_i,
   output logic [31:0]                   rd_data_o,
   output logic                          rd_ack_o
);

   logic [31:0] rd_word;

   always_comb begin
      case (u2_ctrl_pkg::rb_addr_e'(rd_addr_i))
         u2_ctrl_pkg::RB_CLOCK:    rd_word = 32'(regs_i.clock);
         u2_ctrl_pkg::RB_SERDES:   rd_word = 32'(regs_i.serdes);
         u2_ctrl_pkg::RB_ADC:      rd_word = 32'(regs_i.adc);
         u2_ctrl_pkg::RB_LED:      rd_word = 32'(regs_i.led_sw);
         u2_ctrl_pkg::RB_PHY:      rd_word = 32'(regs_i.phy_reset);
         u2_ctrl_pkg::RB_PAGE:     rd_word = 32'(regs_i.page);
         u2_ctrl_pkg::RB_LED_SRC:  rd_word = 32'(regs_i.led_src);
         u2_ctrl_pkg::RB_IRQ_MASK: rd_word = 32'(regs_i.irq_mask);
         u2_ctrl_pkg::RB_IRQ_PEND: rd_word = 32'(pending_i);
         u2_ctrl_pkg::RB_PPS_TIME: rd_word = 32'(pps_time_i);
         // sim_mode, bus_err, then clock divider in the low nibble
         u2_ctrl_pkg::RB_STATUS:   rd_word = {sim_mode_i, bus_err_i, 26'b0, clock_divider_i};
         default:                  rd_word = 32'b0;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         rd_ack_o <= 1'b0;
      end else begin
         rd_ack_o <= rd_stb_i;
      end
   end

   // Data holds between reads
   always_ff @(posedge dsp_clk) begin
      if (rd_stb_i) begin
         rd_data_o <= rd_word;
      end
   end

endmodule

`default_nettype wire

//--- output_lines.sv
// Registered board control pins driven from the register bank.
// Includes the LED source select and the inverted PHY reset.
`timescale 1ns/100ps
`default_nettype none

module output_lines #(
   parameter int PAGE_BITS = 10
) (
   input  logic                        dsp_clk,
   input  logic                        rst_n_i,
   input  u2_ctrl_pkg::ctrl_regs_t     regs_i,
   input  logic [1:0]                  led_hw_i,
   output u2_ctrl_pkg::clock_ctrl_t    clock_ctrl_o,
   output u2_ctrl_pkg::serdes_ctrl_t   serdes_ctrl_o,
   output u2_ctrl_pkg::adc_ctrl_t      adc_ctrl_o,
   output logic [7:0]                  leds_o,
   output logic                        phy_reset_n_o,
   output logic [19-PAGE_BITS:0]       ram_page_o
);

   logic [7:0] led_hw;

   // Only the two low LEDs have a hardware source
   assign led_hw = {6'b0, led_hw_i};

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         clock_ctrl_o  <= '0;
         serdes_ctrl_o <= '0;
         adc_ctrl_o    <= '0;
         leds_o        <= '0;
         phy_reset_n_o <= 1'b1;
         ram_page_o    <= '0;
      end else begin
         clock_ctrl_o  <= regs_i.clock;
         serdes_ctrl_o <= regs_i.serdes;
         adc_ctrl_o    <= regs_i.adc;
         // led_src bit set selects hardware
         leds_o        <= (regs_i.led_src & led_hw) | (~regs_i.led_src & regs_i.led_sw);
         phy_reset_n_o <= ~regs_i.phy_reset;
         ram_page_o    <= regs_i.page[19:PAGE_BITS];
      end
   end

endmodule

`default_nettype wire

//--- irq_controller.sv
// Interrupt controller with rising edge capture, mask and write-one-to-clear.
// irq_o is the OR of all pending and unmasked sources.
`timescale 1ns/100ps
`default_nettype none

module irq_controller (
   input  logic                          dsp_clk,
   input  logic                          rst_n_i,
   input  logic [u2_ctrl_pkg::IRQ_W-1:0] src_i,
   input  logic [u2_ctrl_pkg::IRQ_W-1:0] mask_i,
   input  logic [u2_ctrl_pkg::IRQ_W-1:0] clear_i,
   output logic [u2_ctrl_pkg::IRQ_W-1:0] pending_o,
   output logic                          irq_o
);

   logic [u2_ctrl_pkg::IRQ_W-1:0] src_q;
   logic [u2_ctrl_pkg::IRQ_W-1:0] src_rise;

   // Previous source levels for edge detection
   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         src_q <= '0;
      end else begin
         src_q <= src_i;
      end
   end

   assign src_rise = src_i & ~src_q;

   ////////////////////////////////////////////////////////////
   // Pending bits

   // New edges win over a clear on the same cycle
   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         pending_o <= '0;
      end else begin
         pending_o <= (pending_o & ~clear_i) | src_rise;
      end
   end

   assign irq_o = |(pending_o & mask_i);

   // Clear comes from a single settings write, so it lasts one cycle
   a_clear_pulse: assert property (
      @(posedge dsp_clk) disable iff (!rst_n_i)
         clear_i != '0 |=> clear_i == '0
   );

endmodule

`default_nettype wire

//--- control_regs.sv
// Register bank behind the settings bus.
// Each write loads the field that belongs to its address on the same edge.
// Writes to unmapped addresses raise a sticky bus error.
`timescale 1ns/100ps
`default_nettype none

module control_regs #(
   parameter int PAGE_BITS = 10
) (
   input  logic                                dsp_clk,
   input  logic                                rst_n_i,
   input  u2_ctrl_pkg::settings_t              set_i,
   output u2_ctrl_pkg::ctrl_regs_t             regs_o,
   output logic [u2_ctrl_pkg::IRQ_W-1:0]       irq_clear_o,
   output logic                                bus_err_o
);

   ////////////////////////////////////////////////////////////
   // Setting registers

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         regs_o <= '0;
      end else if (set_i.stb) begin
         case (u2_ctrl_pkg::set_addr_e'(set_i.addr))
            u2_ctrl_pkg::SR_CLOCK: begin
               regs_o.clock <= set_i.data[4:0];
            end
            u2_ctrl_pkg::SR_SERDES: begin
               regs_o.serdes <= set_i.data[3:0];
            end
            u2_ctrl_pkg::SR_ADC: begin
               regs_o.adc <= set_i.data[3:0];
            end
            u2_ctrl_pkg::SR_LED: begin
               regs_o.led_sw <= set_i.data[7:0];
            end
            u2_ctrl_pkg::SR_PHY: begin
               regs_o.phy_reset <= set_i.data[0];
            end
            u2_ctrl_pkg::SR_PAGE: begin
               // Offset bits inside a page come from the bus address, so they read as zero
               regs_o.page <= {set_i.data[19:PAGE_BITS], {PAGE_BITS{1'b0}}};
            end
            u2_ctrl_pkg::SR_LED_SRC: begin
               regs_o.led_src <= set_i.data[7:0];
            end
            u2_ctrl_pkg::SR_IRQ_MASK: begin
               regs_o.irq_mask <= set_i.data[u2_ctrl_pkg::IRQ_W-1:0];
            end
            default: begin
               regs_o <= regs_o;
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // Interrupt clear strobe and bus error

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         irq_clear_o <= '0;
         bus_err_o   <= 1'b0;
      end else begin
         irq_clear_o <= '0;
         if (set_i.stb) begin
            case (u2_ctrl_pkg::set_addr_e'(set_i.addr))
               u2_ctrl_pkg::SR_IRQ_CLEAR: begin
                  irq_clear_o <= set_i.data[u2_ctrl_pkg::IRQ_W-1:0];
               end
               u2_ctrl_pkg::SR_CLOCK, u2_ctrl_pkg::SR_SERDES, u2_ctrl_pkg::SR_ADC,
               u2_ctrl_pkg::SR_LED, u2_ctrl_pkg::SR_PHY, u2_ctrl_pkg::SR_PAGE,
               u2_ctrl_pkg::SR_LED_SRC, u2_ctrl_pkg::SR_IRQ_MASK: begin
                  bus_err_o <= bus_err_o;
               end
               default: begin
                  // Sticky until reset
                  bus_err_o <= 1'b1;
               end
            endcase
         end
      end
   end

   // Host issues at most one write per two cycles
   a_stb_single: assert property (
      @(posedge dsp_clk) disable iff (!rst_n_i)
         set_i.stb |=> !set_i.stb
   );

endmodule

`default_nettype wire

//--- pps_timer.sv
// Master time counter with PPS capture.
// The PPS input is synchronized, edge detected and used to latch the counter.
`timescale 1ns/100ps
`default_nettype none

module pps_timer #(
   parameter int TIME_W = 32
) (
   input  logic              dsp_clk,
   input  logic              rst_n_i,
   input  logic              pps_i,
   output logic              pps_pulse_o,
   output logic [TIME_W-1:0] pps_time_o
);

   logic              pps_meta;
   logic              pps_sync;
   logic              pps_dly;
   logic [TIME_W-1:0] master_time;

   // Two flop synchronizer, then one more flop for the edge
   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         pps_meta <= 1'b0;
         pps_sync <= 1'b0;
         pps_dly  <= 1'b0;
      end else begin
         pps_meta <= pps_i;
         pps_sync <= pps_meta;
         pps_dly  <= pps_sync;
      end
   end

   assign pps_pulse_o = pps_sync & ~pps_dly;

   // Free running, wraps at full scale
   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         master_time <= '0;
      end else begin
         master_time <= master_time + 1'b1;
      end
   end

   // Time of the last PPS edge
   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         pps_time_o <= '0;
      end else if (pps_pulse_o) begin
         pps_time_o <= master_time;
      end
   end

endmodule

`default_nettype wire

//--- u2_ctrl_pkg.sv
// Shared widths, address maps and control groups for the board control core.
// Modules refer to these by scoped name.
`default_nettype none

package u2_ctrl_pkg;

   ////////////////////////////////////////////////////////////
   // Settings bus

   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;

   typedef enum logic [SET_ADDR_W-1:0] {
      SR_CLOCK     = 8'd0,
      SR_SERDES    = 8'd1,
      SR_ADC       = 8'd2,
      SR_LED       = 8'd3,
      SR_PHY       = 8'd4,
      SR_PAGE      = 8'd6,
      SR_LED_SRC   = 8'd8,
      SR_IRQ_MASK  = 8'd9,
      SR_IRQ_CLEAR = 8'd10
   } set_addr_e;

   // One write on the settings bus
   typedef struct packed {
      logic                  stb;
      logic [SET_ADDR_W-1:0] addr;
      logic [SET_DATA_W-1:0] data;
   } settings_t;

   ////////////////////////////////////////////////////////////
   // Interrupts

   localparam int IRQ_W = 8;

   // Bits 5 to 7 are spare and tied low
   typedef enum logic [2:0] {
      IRQ_BUS_ERR    = 3'd0,
      IRQ_PPS        = 3'd1,
      IRQ_PHY        = 3'd2,
      IRQ_LINK       = 3'd3,
      IRQ_CLK_STATUS = 3'd4
   } irq_bit_e;

   ////////////////////////////////////////////////////////////
   // Control groups

   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
   } clock_ctrl_t;

   typedef struct packed {
      logic enable;
      logic prbsen;
      logic loopen;
      logic rx_en;
   } serdes_ctrl_t;

   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

   typedef struct packed {
      clock_ctrl_t      clock;
      serdes_ctrl_t     serdes;
      adc_ctrl_t        adc;
      logic [7:0]       led_sw;
      logic [7:0]       led_src;
      logic             phy_reset;
      logic [19:0]      page;
      logic [IRQ_W-1:0] irq_mask;
   } ctrl_regs_t;

   ////////////////////////////////////////////////////////////
   // Readback word map

   typedef enum logic [3:0] {
      RB_CLOCK    = 4'd0,
      RB_SERDES   = 4'd1,
      RB_ADC      = 4'd2,
      RB_LED      = 4'd3,
      RB_PHY      = 4'd4,
      RB_PAGE     = 4'd5,
      RB_LED_SRC  = 4'd6,
      RB_IRQ_MASK = 4'd7,
      RB_IRQ_PEND = 4'd8,
      RB_PPS_TIME = 4'd9,
      RB_STATUS   = 4'd10
   } rb_addr_e;

endpackage

`default_nettype wire
